// File: common/dl1_pkg.sv
// ==========================================================
// L1 data cache package
// Cache geometry and the shared address, line and way types
// ==========================================================

package dl1_pkg;

	// ==========================================================
	// Geometry
	// ==========================================================
	localparam int DATA_W         = 32;
	localparam int ADDR_W         = 32;
	localparam int WAYS           = 2;
	localparam int SETS           = 16;
	localparam int WORDS_PER_LINE = 4;

	// Address split, byte then word then set index
	localparam int BYTE_OFF_W = 2;
	localparam int WORD_OFF_W = 2;
	localparam int INDEX_W    = 4;
	localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

	// ==========================================================
	// Types
	// ==========================================================
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Line address as seen by L2, tag and index only
	typedef logic [ADDR_W-BYTE_OFF_W-WORD_OFF_W-1:0] line_addr_t;

	typedef logic [WORDS_PER_LINE*DATA_W-1:0] line_t;
	typedef logic [TAG_W-1:0]                 tag_t;
	typedef logic [INDEX_W-1:0]               index_t;
	typedef logic [WORD_OFF_W-1:0]            word_sel_t;

	// One bit per way, one-hot where a single way is meant
	typedef logic [WAYS-1:0] way_t;

endpackage

// File: rtl/dl1_sram.sv
// ==========================================================
// Synchronous dual-port RAM
// One read port with a registered output, one write port
// ==========================================================

module dl1_sram
	import dl1_pkg::*;
#(
	parameter type entry_t = logic,
	parameter int  DEPTH   = SETS
)
(
	input  logic   clk_l1,
	input  index_t rd_addr,
	output entry_t rd_data,
	input  logic   wr_en,
	input  index_t wr_addr,
	input  entry_t wr_data
);

	entry_t mem [DEPTH];

	// Read returns the old entry on a same-address write
	always_ff @(posedge clk_l1)
	begin
		rd_data <= mem[rd_addr];
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

endmodule

// File: dl1_cache/dl1_way_array.sv
// ==========================================================
// L1 data cache way array
// Tag and line RAMs per way, valid and dirty bits,
// hit compare, store merge and victim read-out
// ==========================================================

module dl1_way_array
	import dl1_pkg::*;
(
	input  logic      clk_l1,
	input  logic      rst_n,
	input  index_t    lookup_index,
	input  tag_t      lookup_tag,
	input  word_sel_t lookup_word,
	output logic      hit,
	output way_t      hit_way,
	output word_t     read_word,
	output way_t      set_valid,
	input  way_t      victim_way,
	output logic      victim_dirty,
	output tag_t      victim_tag,
	output line_t     victim_line,
	input  logic      store_en,
	input  word_t     store_word,
	input  logic      fill_en,
	input  way_t      fill_way,
	input  tag_t      fill_tag,
	input  line_t     fill_line
);

	// Set whose RAM entries are on the read outputs
	index_t rd_index_q;
	way_t   valid_q [SETS];
	way_t   dirty_q [SETS];
	tag_t   way_tag [WAYS];
	line_t  way_line [WAYS];
	line_t  hit_line;
	line_t  store_line;

	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_index_q <= '0;
			for (int s = 0; s < SETS; s++)
			begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end
		else
		begin
			rd_index_q <= lookup_index;
			// Fill makes the line valid and clean
			if (fill_en)
			begin
				valid_q[rd_index_q] <= valid_q[rd_index_q] | fill_way;
				dirty_q[rd_index_q] <= dirty_q[rd_index_q] & ~fill_way;
			end
			else if (store_en)
				dirty_q[rd_index_q] <= dirty_q[rd_index_q] | hit_way;
		end
	end

	assign set_valid = valid_q[rd_index_q];

	for (genvar w = 0; w < WAYS; w++)
	begin : g_way
		dl1_sram #(.entry_t(tag_t), .DEPTH(SETS)) u_tag_ram
		(
			.clk_l1  (clk_l1),
			.rd_addr (lookup_index),
			.rd_data (way_tag[w]),
			.wr_en   (fill_en && fill_way[w]),
			.wr_addr (rd_index_q),
			.wr_data (fill_tag)
		);

		// Written on a fill of this way or on a store hit in it
		dl1_sram #(.entry_t(line_t), .DEPTH(SETS)) u_line_ram
		(
			.clk_l1  (clk_l1),
			.rd_addr (lookup_index),
			.rd_data (way_line[w]),
			.wr_en   ((fill_en && fill_way[w]) || (store_en && hit_way[w])),
			.wr_addr (rd_index_q),
			.wr_data (fill_en ? fill_line : store_line)
		);

		assign hit_way[w] = set_valid[w] && (way_tag[w] == lookup_tag);
	end

	assign hit = |hit_way;

	// Hit line and victim read-out, one-hot select by OR
	always_comb
	begin
		hit_line    = '0;
		victim_tag  = '0;
		victim_line = '0;
		for (int w = 0; w < WAYS; w++)
		begin
			if (hit_way[w])
				hit_line = hit_line | way_line[w];
			if (victim_way[w])
			begin
				victim_tag  = victim_tag | way_tag[w];
				victim_line = victim_line | way_line[w];
			end
		end
	end

	assign victim_dirty = |(dirty_q[rd_index_q] & set_valid & victim_way);

	// Word select and store merge
	assign read_word = hit_line[lookup_word*DATA_W +: DATA_W];

	always_comb
	begin
		store_line = hit_line;
		store_line[lookup_word*DATA_W +: DATA_W] = store_word;
	end

endmodule

// File: dl1_cache/dl1_victim_select.sv
// ==========================================================
// L1 data cache victim select
// Invalid way first, else a per-set round-robin pointer
// ==========================================================

module dl1_victim_select
	import dl1_pkg::*;
(
	input  logic   clk_l1,
	input  logic   rst_n,
	input  index_t index,
	input  way_t   set_valid,
	input  logic   advance,
	output way_t   victim_way
);

	localparam int PTR_W = (WAYS > 1) ? $clog2(WAYS) : 1;

	logic [PTR_W-1:0] ptr_q [SETS];
	logic [PTR_W-1:0] victim_idx;

	// Downward scan so the lowest invalid way wins
	always_comb
	begin
		victim_idx = ptr_q[index];
		for (int w = WAYS - 1; w >= 0; w--)
		begin
			if (!set_valid[w])
				victim_idx = PTR_W'(w);
		end
	end

	assign victim_way = way_t'(1) << victim_idx;

	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < SETS; s++)
				ptr_q[s] <= '0;
		end
		else if (advance)
			ptr_q[index] <= victim_idx + 1'b1;
	end

endmodule

// File: dl1_cache/dl1_controller.sv
// ==========================================================
// L1 data cache controller
// Lookup, store, dirty write-back, refill and replay FSM
// with the CPU and L2 valid/ready handshakes
// ==========================================================

module dl1_controller
	import dl1_pkg::*;
(
	input  logic       clk_l1,
	input  logic       rst_n,
	// CPU side
	input  logic       cpu_req_valid,
	output logic       cpu_req_ready,
	input  logic       cpu_req_write,
	input  addr_t      cpu_req_addr,
	input  word_t      cpu_req_wdata,
	output logic       cpu_rsp_valid,
	output word_t      cpu_rsp_rdata,
	// L2 side
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	output logic       mem_req_write,
	output line_addr_t mem_req_addr,
	output line_t      mem_req_wline,
	input  logic       mem_rsp_valid,
	input  line_t      mem_rsp_rline,
	// Way array
	output index_t     lookup_index,
	output tag_t       lookup_tag,
	output word_sel_t  lookup_word,
	input  logic       hit,
	input  word_t      read_word,
	input  way_t       victim_way,
	input  logic       victim_dirty,
	input  tag_t       victim_tag,
	input  line_t      victim_line,
	output logic       store_en,
	output word_t      store_word,
	output logic       fill_en,
	output way_t       fill_way,
	output tag_t       fill_tag,
	output line_t      fill_line
);

	localparam int IDX_LO = BYTE_OFF_W + WORD_OFF_W;

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK,
		ST_REFILL_REQ,
		ST_REFILL_WAIT,
		ST_REPLAY
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   req_write_q;
	addr_t  req_addr_q;
	word_t  req_wdata_q;
	logic   rsp_valid_q;
	word_t  rsp_rdata_q;
	logic   accept;
	index_t req_index;

	assign accept    = cpu_req_valid && (state_q == ST_IDLE);
	assign req_index = req_addr_q[IDX_LO +: INDEX_W];

	// ==========================================================
	// Next state
	// ==========================================================
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
				if (accept)
					state_d = ST_LOOKUP;
			ST_LOOKUP:
				if (hit)
					state_d = ST_IDLE;
				else if (victim_dirty)
					state_d = ST_WRITEBACK;
				else
					state_d = ST_REFILL_REQ;
			ST_WRITEBACK:
				if (mem_req_ready)
					state_d = ST_REFILL_REQ;
			ST_REFILL_REQ:
				if (mem_req_ready)
					state_d = ST_REFILL_WAIT;
			ST_REFILL_WAIT:
				if (mem_rsp_valid)
					state_d = ST_REPLAY;
			// One cycle for the RAMs to read back the filled line
			ST_REPLAY:
				state_d = ST_LOOKUP;
			default:
				state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q     <= ST_IDLE;
			rsp_valid_q <= 1'b0;
		end
		else
		begin
			state_q     <= state_d;
			rsp_valid_q <= (state_q == ST_LOOKUP) && hit;
		end
	end

	// Request and response payload
	always_ff @(posedge clk_l1)
	begin
		if (accept)
		begin
			req_write_q <= cpu_req_write;
			req_addr_q  <= cpu_req_addr;
			req_wdata_q <= cpu_req_wdata;
		end
		if ((state_q == ST_LOOKUP) && hit)
			rsp_rdata_q <= read_word;
	end

	assign cpu_req_ready = (state_q == ST_IDLE);
	assign cpu_rsp_valid = rsp_valid_q;
	assign cpu_rsp_rdata = rsp_rdata_q;

	// ==========================================================
	// Way array control
	// ==========================================================
	// Incoming address while idle so the RAMs read at acceptance
	assign lookup_index = (state_q == ST_IDLE) ? cpu_req_addr[IDX_LO +: INDEX_W] : req_index;
	assign lookup_tag   = req_addr_q[ADDR_W-1 -: TAG_W];
	assign lookup_word  = req_addr_q[BYTE_OFF_W +: WORD_OFF_W];

	assign store_en   = (state_q == ST_LOOKUP) && hit && req_write_q;
	assign store_word = req_wdata_q;

	assign fill_en   = (state_q == ST_REFILL_WAIT) && mem_rsp_valid;
	assign fill_way  = victim_way;
	assign fill_tag  = lookup_tag;
	assign fill_line = mem_rsp_rline;

	// ==========================================================
	// L2 requests
	// ==========================================================
	assign mem_req_valid = (state_q == ST_WRITEBACK) || (state_q == ST_REFILL_REQ);
	assign mem_req_write = (state_q == ST_WRITEBACK);
	// Victim address on write-back, missing line on refill
	assign mem_req_addr  = (state_q == ST_WRITEBACK) ? {victim_tag, req_index}
	                                                 : {lookup_tag, req_index};
	assign mem_req_wline = victim_line;

endmodule

// File: dl1_cache/dl1_cache_top.sv
// ==========================================================
// L1 data cache top level
// Two-way write-back cache between the CPU and L2
// ==========================================================

module dl1_cache_top
	import dl1_pkg::*;
(
	input  logic       clk_l1,
	input  logic       rst_n,
	// CPU side
	input  logic       cpu_req_valid,
	output logic       cpu_req_ready,
	input  logic       cpu_req_write,
	input  addr_t      cpu_req_addr,
	input  word_t      cpu_req_wdata,
	output logic       cpu_rsp_valid,
	output word_t      cpu_rsp_rdata,
	// L2 side
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	output logic       mem_req_write,
	output line_addr_t mem_req_addr,
	output line_t      mem_req_wline,
	input  logic       mem_rsp_valid,
	input  line_t      mem_rsp_rline
);

	index_t    lookup_index;
	tag_t      lookup_tag;
	word_sel_t lookup_word;
	logic      hit;
	word_t     read_word;
	way_t      set_valid;
	way_t      victim_way;
	logic      victim_dirty;
	tag_t      victim_tag;
	line_t     victim_line;
	logic      store_en;
	word_t     store_word;
	logic      fill_en;
	way_t      fill_way;
	tag_t      fill_tag;
	line_t     fill_line;

	dl1_controller u_controller
	(
		.*
	);

	// Hit way is only used inside the way array
	dl1_way_array u_way_array
	(
		.hit_way (),
		.*
	);

	// Pointer moves on every fill of the addressed set
	dl1_victim_select u_victim_select
	(
		.clk_l1     (clk_l1),
		.rst_n      (rst_n),
		.index      (lookup_index),
		.set_valid  (set_valid),
		.advance    (fill_en),
		.victim_way (victim_way)
	);

endmodule

// File: verif/dl1_l2_model.sv
// ==========================================================
// Behavioral L2 memory for the L1 data cache testbench
// Whole-line reads and writes with random back-pressure
// ==========================================================

module dl1_l2_model
	import dl1_pkg::*;
#(
	parameter word_t FILL_KEY = 32'h0
)
(
	input  logic       clk_l1,
	input  logic       rst_n,
	input  logic       mem_req_valid,
	output logic       mem_req_ready,
	input  logic       mem_req_write,
	input  line_addr_t mem_req_addr,
	input  line_t      mem_req_wline,
	output logic       mem_rsp_valid,
	output line_t      mem_rsp_rline
);
	timeunit 1ns;
	timeprecision 100ps;

	// Only lines that were written back are stored
	line_t       mem [line_addr_t];
	logic [15:0] lfsr_q;
	logic [1:0]  stall_q;
	logic        rd_pend_q;

	function automatic logic [15:0] galois_step(input logic [15:0] s);
		logic [15:0] n;
		n = {1'b0, s[15:1]};
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	// Untouched lines follow the word address rule
	function automatic line_t read_line(input line_addr_t la);
		line_t l;
		if (mem.exists(la))
			l = mem[la];
		else
			for (int w = 0; w < WORDS_PER_LINE; w++)
				l[w*DATA_W +: DATA_W] = {2'b00, la, 2'(w)} ^ FILL_KEY;
		return l;
	endfunction

	assign mem_req_ready = (stall_q == 2'd0);

	always @(posedge clk_l1 or negedge rst_n)
	begin : l2_seq
		logic [15:0] s;
		logic [1:0]  stall;
		if (!rst_n)
		begin
			lfsr_q        <= 16'd6;
			stall_q       <= 2'd0;
			rd_pend_q     <= 1'b0;
			mem_rsp_valid <= 1'b0;
			mem_rsp_rline <= '0;
		end
		else
		begin
			mem_rsp_valid <= rd_pend_q;
			rd_pend_q     <= 1'b0;
			if (mem_req_valid && mem_req_ready)
			begin
				// Stall length for the next request, one LFSR step per bit
				s        = lfsr_q;
				stall[1] = s[0];
				s        = galois_step(s);
				stall[0] = s[0];
				s        = galois_step(s);
				lfsr_q  <= s;
				stall_q <= stall;
				if (mem_req_write)
					mem[mem_req_addr] = mem_req_wline;
				else
				begin
					rd_pend_q     <= 1'b1;
					mem_rsp_rline <= read_line(mem_req_addr);
				end
			end
			else if (mem_req_valid)
				stall_q <= stall_q - 2'd1;
		end
	end

endmodule

// File: verif/tb_dl1_cache.sv
// ==========================================================
// L1 data cache testbench
// Directed and random loads and stores against an L2 model
// ==========================================================

module tb_dl1_cache
	import dl1_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int    NUM_TESTS       = 6;
	localparam int    CYCLES_PER_TEST = 200;
	localparam int    RANDOM_OPS      = 40;
	localparam word_t FILL_KEY        = 32'h5A3C_96E1;
	localparam addr_t ADDR_A          = 32'h0000_1044;
	localparam addr_t ADDR_B0         = 32'h0001_0094;

	logic       clk_l1;
	logic       rst_n;
	logic       cpu_req_valid;
	logic       cpu_req_ready;
	logic       cpu_req_write;
	addr_t      cpu_req_addr;
	word_t      cpu_req_wdata;
	logic       cpu_rsp_valid;
	word_t      cpu_rsp_rdata;
	logic       mem_req_valid;
	logic       mem_req_ready;
	logic       mem_req_write;
	line_addr_t mem_req_addr;
	line_t      mem_req_wline;
	logic       mem_rsp_valid;
	line_t      mem_rsp_rline;

	int          errors       = 0;
	int          checks       = 0;
	int          stall_fails  = 0;
	int          busy_fails   = 0;
	int          hit_fails    = 0;
	int          test_num     = 0;
	int          fail_mark    = 0;
	int          rd_count     = 0;
	int          wr_count     = 0;
	int          stall_cycles = 0;
	line_addr_t  last_rd_addr;
	line_addr_t  last_wr_addr;
	line_t       last_wr_line;
	logic        expect_hit   = 1'b0;
	logic        busy         = 1'b0;
	logic        hit_accept;
	logic [15:0] lfsr_q       = 16'd6;
	word_t       ref_mem [addr_t];

	dl1_cache_top UUT (.*);

	dl1_l2_model #(.FILL_KEY(FILL_KEY)) u_l2 (.*);

	initial
	begin
		clk_l1 = 1'b0;
		forever #5 clk_l1 = ~clk_l1;
	end

	initial
	begin
		repeat ((NUM_TESTS * CYCLES_PER_TEST) + 16) @(posedge clk_l1);
		$display("Watchdog expired before the tests completed");
		$display("CHECKS FAILED");
		$finish;
	end

	// L2 traffic and CPU busy tracking
	always @(posedge clk_l1)
	begin
		if (rst_n && mem_req_valid && mem_req_ready)
		begin
			if (mem_req_write)
			begin
				wr_count     <= wr_count + 1;
				last_wr_addr <= mem_req_addr;
				last_wr_line <= mem_req_wline;
			end
			else
			begin
				rd_count     <= rd_count + 1;
				last_rd_addr <= mem_req_addr;
			end
		end
		if (rst_n && mem_req_valid && !mem_req_ready)
			stall_cycles <= stall_cycles + 1;
		if (cpu_req_valid && cpu_req_ready)
			busy <= 1'b1;
		else if (cpu_rsp_valid)
			busy <= 1'b0;
	end

	// ==========================================================
	// Protocol assertions
	// ==========================================================
	assign hit_accept = cpu_req_valid && cpu_req_ready && expect_hit;

	stall_hold: assert property (@(posedge clk_l1) disable iff (!rst_n)
		(mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req_write)
		&& $stable(mem_req_addr) && $stable(mem_req_wline)))
	else
	begin
		$display("L2 request dropped or changed while mem_req_ready was low");
		stall_fails++;
	end

	busy_hold: assert property (@(posedge clk_l1) disable iff (!rst_n)
		(busy && !cpu_rsp_valid) |-> !cpu_req_ready)
	else
	begin
		$display("cpu_req_ready went high before the response");
		busy_fails++;
	end

	// Hit responds exactly two edges after acceptance, with no L2 request
	hit_timing: assert property (@(posedge clk_l1) disable iff (!rst_n)
		$past(hit_accept, 2) |-> (cpu_rsp_valid && !$past(cpu_rsp_valid)
		&& !mem_req_valid && !$past(mem_req_valid)))
	else
	begin
		$display("Load hit response was not two edges after acceptance or went to L2");
		hit_fails++;
	end

	// ==========================================================
	// Helpers
	// ==========================================================
	function automatic logic [15:0] galois_step(input logic [15:0] s);
		logic [15:0] n;
		n = {1'b0, s[15:1]};
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val    = {val[14:0], lfsr_q[0]};
			lfsr_q = galois_step(lfsr_q);
		end
	endtask

	// Stored word if written, else the L2 fill rule
	function automatic word_t expected_word(input addr_t addr);
		word_t w;
		if (ref_mem.exists({addr[31:2], 2'b00}))
			w = ref_mem[{addr[31:2], 2'b00}];
		else
			w = {2'b00, addr[31:2]} ^ FILL_KEY;
		return w;
	endfunction

	function automatic line_t expected_line(input line_addr_t la);
		line_t l;
		for (int w = 0; w < WORDS_PER_LINE; w++)
			l[w*DATA_W +: DATA_W] = expected_word({la, 2'(w), 2'b00});
		return l;
	endfunction

	function automatic int total_failures();
		return errors + stall_fails + busy_fails + hit_fails;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s expected %08h got %08h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_line(input string name, input line_t got, input line_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s expected %032h got %032h", name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		int now;
		now = total_failures();
		test_num++;
		$display("Test %0d %s: %0d failures", test_num, name, now - fail_mark);
		fail_mark = now;
	endtask

	// One CPU request, held until accepted, then wait for the response
	task automatic run_access(input logic write, input addr_t addr, input word_t wdata,
		input logic hit_expected);
		@(negedge clk_l1);
		cpu_req_valid = 1'b1;
		cpu_req_write = write;
		cpu_req_addr  = addr;
		cpu_req_wdata = wdata;
		expect_hit    = hit_expected;
		while (!cpu_req_ready)
			@(negedge clk_l1);
		@(negedge clk_l1);
		cpu_req_valid = 1'b0;
		expect_hit    = 1'b0;
		while (!cpu_rsp_valid)
			@(negedge clk_l1);
		if (write)
			ref_mem[{addr[31:2], 2'b00}] = wdata;
		else
			check_word("cpu_rsp_rdata", cpu_rsp_rdata, expected_word(addr));
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial
	begin : main
		int          rd_mark;
		int          wr_mark;
		int          stall_mark;
		int          failures;
		logic [15:0] r;
		logic [15:0] d;
		addr_t       addr;
		rst_n         = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_write = 1'b0;
		cpu_req_addr  = '0;
		cpu_req_wdata = '0;
		repeat (16) @(posedge clk_l1);
		@(negedge clk_l1);
		rst_n = 1'b1;
		@(negedge clk_l1);

		check_word("cpu_req_ready", word_t'(cpu_req_ready), 32'd1);
		check_word("cpu_rsp_valid", word_t'(cpu_rsp_valid), 32'd0);
		check_word("mem_req_valid", word_t'(mem_req_valid), 32'd0);
		report_test("reset state");

		// Miss then hit on one line
		rd_mark = rd_count;
		run_access(1'b0, ADDR_A, '0, 1'b0);
		check_word("l2 read count", word_t'(rd_count - rd_mark), 32'd1);
		check_word("mem_req_addr", word_t'(last_rd_addr), word_t'(ADDR_A[31:4]));
		run_access(1'b0, ADDR_A, '0, 1'b1);
		check_word("l2 read count", word_t'(rd_count - rd_mark), 32'd1);
		report_test("load miss and hit");

		run_access(1'b1, 32'h0000_2088, 32'hCAFE_0123, 1'b0);
		for (int w = 0; w < WORDS_PER_LINE; w++)
			run_access(1'b0, {28'h0000208, 2'(w), 2'b00}, '0, 1'b1);
		report_test("store and line reload");

		// Third store to set 9 evicts the dirty first line
		wr_mark = wr_count;
		run_access(1'b1, ADDR_B0, 32'h1111_0001, 1'b0);
		run_access(1'b1, 32'h0002_0098, 32'h2222_0002, 1'b0);
		run_access(1'b1, 32'h0003_009C, 32'h3333_0003, 1'b0);
		check_word("l2 write count", word_t'(wr_count - wr_mark), 32'd1);
		check_word("mem_req_addr", word_t'(last_wr_addr), word_t'(ADDR_B0[31:4]));
		check_line("mem_req_wline", last_wr_line, expected_line(ADDR_B0[31:4]));
		run_access(1'b0, ADDR_B0, '0, 1'b0);
		wr_mark = wr_count;
		run_access(1'b0, 32'h0001_00C0, '0, 1'b0);
		run_access(1'b0, 32'h0002_00C4, '0, 1'b0);
		run_access(1'b0, 32'h0003_00C8, '0, 1'b0);
		check_word("l2 write count", word_t'(wr_count - wr_mark), 32'd0);
		report_test("dirty eviction");

		// Set 5 thrash keeps L2 busy under back-pressure
		stall_mark = stall_cycles;
		for (int i = 0; i < 6; i++)
			run_access(1'b1, {20'h00000, 4'(i % 3 + 1), 8'h54}, 32'hB000_0000 + word_t'(i),
				1'b0);
		for (int i = 0; i < 3; i++)
			run_access(1'b0, {20'h00000, 4'(i + 1), 8'h54}, '0, 1'b0);
		checks++;
		assert (stall_cycles > stall_mark)
		else
		begin
			$display("L2 never held mem_req_ready low during the back-pressure test");
			errors++;
		end
		report_test("back-pressure");

		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			draw_bits(6, r);
			draw_bits(16, d);
			addr = {22'h001, r[4:3], 3'b001, r[2], r[1:0], 2'b00};
			run_access(r[5], addr, {16'(i), d}, 1'b0);
		end
		report_test("random mix");

		failures = total_failures();
		$display("Tests run %0d, checks %0d, failures %0d", test_num, checks, failures);
		if (failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: sim.f
common/dl1_pkg.sv
rtl/dl1_sram.sv
dl1_cache/dl1_way_array.sv
dl1_cache/dl1_victim_select.sv
dl1_cache/dl1_controller.sv
dl1_cache/dl1_cache_top.sv
verif/dl1_l2_model.sv
verif/tb_dl1_cache.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_dl1_cache -Mdir obj_dir -f sim.f \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_dl1_cache 2>&1 | tee sim.log

grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
